//--- verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

   localparam int DATA_W = 8;
   localparam logic [DATA_W-1:0] PC_RESET = 8'h08;   // Nibble 8, byte 4
   localparam logic [DATA_W-1:0] SP_RESET = 8'hFF;

   typedef enum logic [3:0] {
      OP_NOP  = 4'h0,
      OP_ADD  = 4'h1,
      OP_SUB  = 4'h2,
      OP_MUL  = 4'h3,
      OP_NAND = 4'h4,
      OP_XOR  = 4'h5,
      OP_IMM  = 4'h6,
      OP_LD1  = 4'h7,
      OP_LD2  = 4'h8,
      OP_ST   = 4'h9,
      OP_MOV  = 4'hA,
      OP_PUSH = 4'hB,
      OP_POP  = 4'hC,
      OP_JZ   = 4'hD,
      OP_OUT  = 4'hE,
      OP_HALT = 4'hF
   } opcode_e;

   typedef enum logic [4:0] {
      ALU_ADD     = 5'd0,
      ALU_SUB     = 5'd1,
      ALU_MUL     = 5'd2,
      ALU_NAND    = 5'd3,
      ALU_R0XR1   = 5'd4,
      ALU_XOR     = 5'd5,
      ALU_R2XR3   = 5'd6,
      ALU_C0      = 5'd16,
      ALU_C1      = 5'd17,
      ALU_C2      = 5'd18,
      ALU_C3      = 5'd19,
      ALU_PC_SKIP = 5'd20,   // First nibble past an IMM operand
      ALU_PC_INC  = 5'd21,
      ALU_R3_NIB  = 5'd22,   // r3 as a nibble address
      ALU_SP_INC  = 5'd23,
      ALU_DIN     = 5'd24,
      ALU_SP      = 5'd25,
      ALU_SP_DEC  = 5'd26,
      ALU_PC      = 5'd27,
      ALU_R2      = 5'd28
   } alu_sel_e;

   typedef enum logic [2:0] {
      RB_MEM0 = 3'd0,
      RB_MEM1 = 3'd1,
      RB_MEM2 = 3'd2,
      RB_MEM3 = 3'd3,
      RB_ALU0 = 3'd4,
      RB_ALU1 = 3'd5,
      RB_ALU2 = 3'd6,
      RB_ALU3 = 3'd7
   } rb_sel_e;

   typedef enum logic [2:0] {
      S_IDLE, S_FETCH, S_DECODE, S_EXEC, S_MEMRD, S_WRBACK, S_OUTWAIT
   } state_e;

   typedef enum logic [1:0] {
      ADDR_PC, ADDR_PC1, ADDR_R3, ADDR_SP
   } addr_sel_e;

   typedef struct packed {
      alu_sel_e  alu_sel;
      rb_sel_e   rb_sel;
      logic      rb_we;
      logic      sp_we;
      logic      pc_we;
      logic      ir_we;
      addr_sel_e addr_sel;
      logic      mem_we;
   } ctrl_t;

   typedef struct packed {
      logic              we;
      logic [DATA_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } mem_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } load_beat_t;

endpackage

`default_nettype wire

//--- verilog/cpu_control.sv
`default_nettype none

module cpu_control (
   input  logic             clk,
   input  logic             nRst,
   input  cpu_pkg::opcode_e ir,
   input  logic             z,
   input  logic             start,
   input  logic             out_ready,
   output cpu_pkg::ctrl_t   ctrl,
   output logic             out_valid,
   output logic             halted
);
   import cpu_pkg::*;

   state_e state;
   state_e state_nxt;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state <= S_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt     = state;
      ctrl.alu_sel  = ALU_ADD;
      ctrl.rb_sel   = RB_MEM0;
      ctrl.rb_we    = 1'b0;
      ctrl.sp_we    = 1'b0;
      ctrl.pc_we    = 1'b0;
      ctrl.ir_we    = 1'b0;
      ctrl.addr_sel = ADDR_PC;
      ctrl.mem_we   = 1'b0;
      case (state)
         S_IDLE: begin
            if (start) state_nxt = S_FETCH;
         end
         S_FETCH: begin
            state_nxt = S_DECODE;   // Byte at pc>>1 is being read
         end
         S_DECODE: begin
            ctrl.ir_we   = 1'b1;
            ctrl.pc_we   = 1'b1;
            ctrl.alu_sel = ALU_PC_INC;
            state_nxt    = S_EXEC;
         end
         S_EXEC: begin
            state_nxt = S_FETCH;
            case (ir)
               OP_ADD, OP_SUB, OP_MUL, OP_NAND, OP_XOR: begin
                  ctrl.rb_we  = 1'b1;
                  ctrl.rb_sel = RB_ALU1;
                  case (ir)
                     OP_ADD:  ctrl.alu_sel = ALU_ADD;
                     OP_SUB:  ctrl.alu_sel = ALU_SUB;
                     OP_MUL:  ctrl.alu_sel = ALU_MUL;
                     OP_NAND: ctrl.alu_sel = ALU_NAND;
                     default: ctrl.alu_sel = ALU_XOR;
                  endcase
               end
               OP_MOV: begin
                  ctrl.rb_we   = 1'b1;
                  ctrl.rb_sel  = RB_ALU3;
                  ctrl.alu_sel = ALU_R0XR1;   // r0 never leaves zero
               end
               OP_IMM, OP_LD1, OP_LD2: state_nxt = S_MEMRD;
               OP_POP: begin
                  ctrl.sp_we   = 1'b1;
                  ctrl.alu_sel = ALU_SP_INC;
                  state_nxt    = S_MEMRD;
               end
               OP_ST: begin
                  ctrl.addr_sel = ADDR_R3;
                  ctrl.mem_we   = 1'b1;
               end
               OP_PUSH: begin
                  ctrl.addr_sel = ADDR_SP;   // Old sp addresses the write
                  ctrl.mem_we   = 1'b1;
                  ctrl.sp_we    = 1'b1;
                  ctrl.alu_sel  = ALU_SP_DEC;
               end
               OP_JZ: begin
                  ctrl.pc_we   = z;
                  ctrl.alu_sel = ALU_R3_NIB;
               end
               OP_OUT:  state_nxt = S_OUTWAIT;
               OP_HALT: state_nxt = S_IDLE;
               default: state_nxt = S_FETCH;
            endcase
         end
         S_MEMRD: begin
            if (ir == OP_IMM) ctrl.addr_sel = ADDR_PC1;
            else if (ir == OP_POP) ctrl.addr_sel = ADDR_SP;
            else ctrl.addr_sel = ADDR_R3;
            state_nxt = S_WRBACK;
         end
         S_WRBACK: begin
            ctrl.rb_we = 1'b1;
            if (ir == OP_IMM) begin
               ctrl.rb_sel  = RB_MEM3;
               ctrl.pc_we   = 1'b1;   // Step over the operand byte
               ctrl.alu_sel = ALU_PC_SKIP;
            end else if (ir == OP_LD1) begin
               ctrl.rb_sel = RB_MEM1;
            end else begin
               ctrl.rb_sel = RB_MEM2;
            end
            state_nxt = S_FETCH;
         end
         S_OUTWAIT: begin
            if (out_ready) state_nxt = S_FETCH;
         end
         default: state_nxt = S_IDLE;
      endcase
   end

   assign out_valid = (state == S_OUTWAIT);
   assign halted    = (state == S_IDLE);

   assert property (@(posedge clk) disable iff (!nRst)
      out_valid && !out_ready |=> out_valid);

endmodule

`default_nettype wire

//--- verilog/cpu_regfile.sv
`default_nettype none

module cpu_regfile (
   input  logic                       clk,
   input  logic                       nRst,
   input  cpu_pkg::ctrl_t             ctrl,
   input  logic [cpu_pkg::DATA_W-1:0] result,
   input  logic [cpu_pkg::DATA_W-1:0] mem_rdata,
   output logic [cpu_pkg::DATA_W-1:0] r1,
   output logic [cpu_pkg::DATA_W-1:0] r2,
   output logic [cpu_pkg::DATA_W-1:0] r3,
   output logic [cpu_pkg::DATA_W-1:0] sp,
   output logic [cpu_pkg::DATA_W-1:0] r0,
   output logic                       z
);
   import cpu_pkg::*;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         r0 <= '0;   // MOV relies on r0 staying zero
         r1 <= '0;
         r2 <= '0;
         r3 <= '0;
         sp <= SP_RESET;
      end else begin
         if (ctrl.sp_we) sp <= result;
         if (ctrl.rb_we) begin
            case (ctrl.rb_sel)
               RB_MEM0: r0 <= mem_rdata;
               RB_MEM1: r1 <= mem_rdata;
               RB_MEM2: r2 <= mem_rdata;
               RB_MEM3: r3 <= mem_rdata;
               RB_ALU0: r0 <= result;
               RB_ALU1: r1 <= result;
               RB_ALU2: r2 <= result;
               RB_ALU3: r3 <= result;
               default: r0 <= r0;
            endcase
         end
      end
   end

   assign z = (r1 == r2);   // JZ condition

endmodule

`default_nettype wire

//--- verilog/cpu_alu.sv
`default_nettype none

module cpu_alu (
   input  cpu_pkg::ctrl_t             ctrl,
   input  logic [cpu_pkg::DATA_W-1:0] r0,
   input  logic [cpu_pkg::DATA_W-1:0] r1,
   input  logic [cpu_pkg::DATA_W-1:0] r2,
   input  logic [cpu_pkg::DATA_W-1:0] r3,
   input  logic [cpu_pkg::DATA_W-1:0] sp,
   input  logic [cpu_pkg::DATA_W-1:0] pc,
   input  logic [cpu_pkg::DATA_W-1:0] mem_rdata,
   output logic [cpu_pkg::DATA_W-1:0] result
);
   import cpu_pkg::*;

   logic [DATA_W:0] pc_round;

   // Bits [DATA_W:1] give the operand byte of an IMM
   assign pc_round = {1'b0, pc} + (DATA_W+1)'(1);

   always_comb begin
      case (ctrl.alu_sel)
         ALU_ADD:     result = r1 + r2;
         ALU_SUB:     result = r1 - r2;
         ALU_MUL:     result = r1 * r2;   // Low byte only
         ALU_NAND:    result = ~(r1 & r2);
         ALU_R0XR1:   result = r0 ^ r1;
         ALU_XOR:     result = r1 ^ r2;
         ALU_R2XR3:   result = r2 ^ r3;
         ALU_C0:      result = DATA_W'(0);
         ALU_C1:      result = DATA_W'(1);
         ALU_C2:      result = DATA_W'(2);
         ALU_C3:      result = DATA_W'(3);
         ALU_PC_SKIP: result = {pc_round[DATA_W-1:1], 1'b0} + DATA_W'(2);
         ALU_PC_INC:  result = pc + DATA_W'(1);
         ALU_R3_NIB:  result = {r3[DATA_W-2:0], 1'b0};
         ALU_SP_INC:  result = sp + DATA_W'(1);
         ALU_DIN:     result = mem_rdata;
         ALU_SP:      result = sp;
         ALU_SP_DEC:  result = sp - DATA_W'(1);
         ALU_PC:      result = pc;
         ALU_R2:      result = r2;
         default:     result = mem_rdata;
      endcase
   end

endmodule

`default_nettype wire

//--- verilog/cpu_fetch.sv
`default_nettype none

module cpu_fetch (
   input  logic                       clk,
   input  logic                       nRst,
   input  cpu_pkg::ctrl_t             ctrl,
   input  logic [cpu_pkg::DATA_W-1:0] result,
   input  logic [cpu_pkg::DATA_W-1:0] mem_rdata,
   output logic [cpu_pkg::DATA_W-1:0] pc,
   output cpu_pkg::opcode_e           ir
);
   import cpu_pkg::*;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         pc <= PC_RESET;
         ir <= OP_NOP;
      end else begin
         if (ctrl.pc_we) pc <= result;
         if (ctrl.ir_we) begin
            // Even nibble address sits in the high half
            if (pc[0]) ir <= opcode_e'(mem_rdata[3:0]);
            else ir <= opcode_e'(mem_rdata[7:4]);
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/cpu_memory.sv
`default_nettype none

module cpu_memory (
   input  logic                       clk,
   input  cpu_pkg::load_beat_t        load,
   input  logic                       load_fire,
   input  cpu_pkg::mem_req_t          req,
   output logic [cpu_pkg::DATA_W-1:0] rdata
);
   import cpu_pkg::*;

   logic [DATA_W-1:0] ram [2**DATA_W];

   always_ff @(posedge clk) begin
      if (load_fire) begin
         ram[load.addr] <= load.data;   // Program load while halted
      end else if (req.we) begin
         ram[req.addr] <= req.wdata;
      end
      rdata <= ram[req.addr];
   end

   assert property (@(posedge clk) load_fire |-> !req.we);

endmodule

`default_nettype wire

//--- verilog/nibble_cpu.sv
`default_nettype none

module nibble_cpu (
   input  logic                       clk,
   input  logic                       nRst,
   input  cpu_pkg::load_beat_t        load,
   input  logic                       load_valid,
   output logic                       load_ready,
   input  logic                       start,
   output logic [cpu_pkg::DATA_W-1:0] out_data,
   output logic                       out_valid,
   input  logic                       out_ready,
   output logic                       halted
);
   import cpu_pkg::*;

   ctrl_t             ctrl;
   opcode_e           ir;
   logic              z;
   logic [DATA_W-1:0] result;
   logic [DATA_W-1:0] mem_rdata;
   logic [DATA_W-1:0] pc;
   logic [DATA_W-1:0] sp;
   logic [DATA_W-1:0] r0;
   logic [DATA_W-1:0] r1;
   logic [DATA_W-1:0] r2;
   logic [DATA_W-1:0] r3;
   logic [DATA_W:0]   pc_round;
   mem_req_t          req;
   logic              load_fire;

   assign load_ready = halted;
   assign load_fire  = load_valid && load_ready;
   assign out_data   = r1;

   assign pc_round = {1'b0, pc} + (DATA_W+1)'(1);   // pc is one past the IMM here

   always_comb begin
      req.we    = ctrl.mem_we;
      req.wdata = r1;   // ST and PUSH both store r1
      case (ctrl.addr_sel)
         ADDR_PC:  req.addr = {1'b0, pc[DATA_W-1:1]};
         ADDR_PC1: req.addr = pc_round[DATA_W:1];
         ADDR_R3:  req.addr = r3;
         default:  req.addr = sp;
      endcase
   end

   cpu_control cpu_control_i (
      .clk       (clk),
      .nRst      (nRst),
      .ir        (ir),
      .z         (z),
      .start     (start),
      .out_ready (out_ready),
      .ctrl      (ctrl),
      .out_valid (out_valid),
      .halted    (halted)
   );

   cpu_regfile cpu_regfile_i (
      .clk       (clk),
      .nRst      (nRst),
      .ctrl      (ctrl),
      .result    (result),
      .mem_rdata (mem_rdata),
      .r1        (r1),
      .r2        (r2),
      .r3        (r3),
      .sp        (sp),
      .r0        (r0),
      .z         (z)
   );

   cpu_alu cpu_alu_i (
      .ctrl      (ctrl),
      .r0        (r0),
      .r1        (r1),
      .r2        (r2),
      .r3        (r3),
      .sp        (sp),
      .pc        (pc),
      .mem_rdata (mem_rdata),
      .result    (result)
   );

   cpu_fetch cpu_fetch_i (
      .clk       (clk),
      .nRst      (nRst),
      .ctrl      (ctrl),
      .result    (result),
      .mem_rdata (mem_rdata),
      .pc        (pc),
      .ir        (ir)
   );

   cpu_memory cpu_memory_i (
      .clk       (clk),
      .load      (load),
      .load_fire (load_fire),
      .req       (req),
      .rdata     (mem_rdata)
   );

endmodule

`default_nettype wire

//--- bench/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// Programs start at byte 4 (nibble 8); operands are read through r3
task automatic fill_tests();
   logic [DATA_W-1:0] a;
   logic [DATA_W-1:0] b;

   // IMM at even and odd nibbles, skipped nibble after IMM holds a HALT
   new_test("arith", 20);
   add_beat(8'h40, 8'h17);
   add_beat(8'h41, 8'h05);
   add_beat(8'h04, 8'h6F);   // IMM, low nibble never runs
   add_beat(8'h05, 8'h40);
   add_beat(8'h06, 8'h76);   // LD1, IMM
   add_beat(8'h07, 8'h41);
   add_beat(8'h08, 8'h8E);   // LD2, OUT
   add_beat(8'h09, 8'h1E);   // ADD, OUT
   add_beat(8'h0A, 8'h2E);   // SUB, OUT
   add_beat(8'h0B, 8'h3E);   // MUL, OUT
   add_beat(8'h0C, 8'h4E);   // NAND, OUT
   add_beat(8'h0D, 8'h5E);   // XOR, OUT
   add_beat(8'h0E, 8'hA7);   // MOV, LD1 through the moved address
   add_beat(8'h0F, 8'hEF);
   a = 8'h17;
   b = 8'h05;
   add_expect(a);
   a = a + b;
   add_expect(a);
   a = a - b;
   add_expect(a);
   a = a * b;
   add_expect(a);
   a = ~(a & b);
   add_expect(a);
   a = a ^ b;
   add_expect(a);
   add_beat(a, 8'h6D);   // Byte that r3 points at after MOV
   add_expect(8'h6D);

   new_test("memory", 18);
   add_beat(8'h40, 8'h5A);
   add_beat(8'h41, 8'hC3);
   add_beat(8'h04, 8'h60);
   add_beat(8'h05, 8'h40);
   add_beat(8'h06, 8'h76);   // LD1 from 0x40, IMM
   add_beat(8'h07, 8'h80);
   add_beat(8'h08, 8'h96);   // ST to 0x80, IMM
   add_beat(8'h09, 8'h41);
   add_beat(8'h0A, 8'h76);   // LD1 from 0x41, IMM
   add_beat(8'h0B, 8'h81);
   add_beat(8'h0C, 8'h96);   // ST to 0x81, IMM
   add_beat(8'h0D, 8'h80);
   add_beat(8'h0E, 8'h7E);   // LD1 back from 0x80, OUT
   add_beat(8'h0F, 8'h60);
   add_beat(8'h10, 8'h81);
   add_beat(8'h11, 8'h85);   // LD2 back from 0x81, XOR
   add_beat(8'h12, 8'hEF);
   add_expect(8'h5A);
   add_expect(8'h5A ^ 8'hC3);

   new_test("stack", 18);
   add_beat(8'h40, 8'h11);
   add_beat(8'h41, 8'h22);
   add_beat(8'h04, 8'h60);
   add_beat(8'h05, 8'h40);
   add_beat(8'h06, 8'h7B);   // LD1, PUSH to SP_RESET
   add_beat(8'h07, 8'h60);
   add_beat(8'h08, 8'h41);
   add_beat(8'h09, 8'h7B);   // LD1, PUSH
   add_beat(8'h0A, 8'hC2);   // POP, SUB clears r1
   add_beat(8'h0B, 8'h1E);   // ADD copies r2, OUT
   add_beat(8'h0C, 8'hC2);   // POP, SUB
   add_beat(8'h0D, 8'hE6);   // OUT, IMM at odd nibble
   add_beat(8'h0E, SP_RESET - 8'd1);   // Slot of the second PUSH
   add_beat(8'h0F, 8'h7E);   // LD1, OUT
   add_beat(8'h10, 8'hF0);
   a = 8'h22;
   add_expect(a);
   b = 8'h11;
   add_expect(a - b);
   add_expect(a);

   new_test("branch", 16);
   add_beat(8'h40, 8'h33);
   add_beat(8'h41, 8'h44);
   add_beat(8'h20, 8'hF0);   // Wrong branch target halts silently
   add_beat(8'h04, 8'h60);
   add_beat(8'h05, 8'h40);
   add_beat(8'h06, 8'h78);   // LD1, LD2 give equal values
   add_beat(8'h07, 8'h60);
   add_beat(8'h08, 8'h0B);
   add_beat(8'h09, 8'hDE);   // JZ taken to byte 0x0B
   add_beat(8'h0A, 8'h2E);   // Skipped SUB, OUT
   add_beat(8'h0B, 8'h60);
   add_beat(8'h0C, 8'h41);
   add_beat(8'h0D, 8'h86);   // LD2, IMM at odd nibble
   add_beat(8'h0E, 8'h20);
   add_beat(8'h0F, 8'hDE);   // JZ not taken, OUT
   add_beat(8'h10, 8'hF0);
   add_expect(8'h33);

   // Back to back OUTs to catch lost or doubled bytes
   new_test("burst", 16);
   add_beat(8'h40, 8'h01);
   add_beat(8'h04, 8'h60);
   add_beat(8'h05, 8'h40);
   add_beat(8'h06, 8'h78);
   add_beat(8'h07, 8'hE1);
   add_beat(8'h08, 8'hE1);
   add_beat(8'h09, 8'hE1);
   add_beat(8'h0A, 8'hEE);
   add_beat(8'h0B, 8'hF0);
   add_expect(8'h01);
   add_expect(8'h02);
   add_expect(8'h03);
   add_expect(8'h04);
   add_expect(8'h04);
endtask

`endif

//--- bench/nibble_cpu_tb.sv
`default_nettype none

module nibble_cpu_tb;
   import cpu_pkg::*;

   localparam int MAX_TESTS = 8;
   localparam int MAX_BEATS = 32;
   localparam int MAX_OUT   = 16;

   logic              clk;
   logic              nRst;
   load_beat_t        load;
   logic              load_valid;
   logic              load_ready;
   logic              start;
   logic [DATA_W-1:0] out_data;
   logic              out_valid;
   logic              out_ready;
   logic              halted;

   string             test_name [MAX_TESTS];
   load_beat_t        beats     [MAX_TESTS][MAX_BEATS];
   int                n_beats   [MAX_TESTS];
   logic [DATA_W-1:0] exp_out   [MAX_TESTS][MAX_OUT];
   int                n_out     [MAX_TESTS];
   int                n_instr   [MAX_TESTS];
   int                n_tests;
   int                err_cnt;
   int                cycles;
   int                cycle_limit;
   logic [31:0]       rng;

   nibble_cpu nibble_cpu_i (
      .clk        (clk),
      .nRst       (nRst),
      .load       (load),
      .load_valid (load_valid),
      .load_ready (load_ready),
      .start      (start),
      .out_data   (out_data),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .halted     (halted)
   );

   task automatic new_test(input string name, input int instrs);
      test_name[n_tests] = name;
      n_instr[n_tests]   = instrs;
      n_beats[n_tests]   = 0;
      n_out[n_tests]     = 0;
      n_tests            = n_tests + 1;
   endtask

   task automatic add_beat(input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] data);
      beats[n_tests-1][n_beats[n_tests-1]] = '{addr: addr, data: data};
      n_beats[n_tests-1] = n_beats[n_tests-1] + 1;
   endtask

   task automatic add_expect(input logic [DATA_W-1:0] value);
      exp_out[n_tests-1][n_out[n_tests-1]] = value;
      n_out[n_tests-1] = n_out[n_tests-1] + 1;
   endtask

   `include "tb_programs.svh"

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic check_byte(input string name, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
      if (expected !== actual) begin
         err_cnt = err_cnt + 1;
         $display("Error: test %s expected %h actual %h", name, expected, actual);
         $display("Test FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_halted(input string name, input logic expected, input logic actual);
      if (expected !== actual) begin
         err_cnt = err_cnt + 1;
         $display("Error: test %s expected %b actual %b", name, expected, actual);
         $display("Test FAILED");
         $fatal(1);
      end
   endtask

   task automatic apply_reset();
      @(posedge clk);
      nRst <= 1'b0;
      repeat (16) @(posedge clk);
      nRst <= 1'b1;
      @(posedge clk);
   endtask

   task automatic load_program(input int t);
      for (int i = 0; i < n_beats[t]; i++) begin
         load       <= beats[t][i];
         load_valid <= 1'b1;
         do @(posedge clk); while (!load_ready);
      end
      load_valid <= 1'b0;
      start      <= 1'b1;   // Seen in IDLE on the next edge
      @(posedge clk);
      start      <= 1'b0;
   endtask

   task automatic collect_output(input int t);
      int  got;
      bit  done;
      got  = 0;
      done = 0;
      @(negedge clk);
      check_halted({test_name[t], " running"}, 1'b0, halted);
      while (!done) begin
         @(negedge clk);
         if (out_valid && out_ready) begin
            if (got >= n_out[t]) begin
               err_cnt = err_cnt + 1;
               $display("Test %s sent more output bytes than expected", test_name[t]);
               $display("Test FAILED");
               $fatal(1);
            end else begin
               check_byte(test_name[t], exp_out[t][got], out_data);
               got = got + 1;
            end
         end
         if (halted) begin
            done = 1;
         end else begin
            @(posedge clk);
            rng = lcg_next(rng);
            out_ready <= rng[16];
         end
      end
      if (got != n_out[t]) begin
         err_cnt = err_cnt + 1;
         $display("Test %s halted after %0d of %0d output bytes", test_name[t], got, n_out[t]);
         $display("Test FAILED");
         $fatal(1);
      end
      @(posedge clk);
      @(negedge clk);
      check_halted({test_name[t], " halted"}, 1'b1, halted);   // Stays idle after HALT
      check_halted({test_name[t], " load_ready"}, 1'b1, load_ready);
   endtask

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Run limit from the table, plus reset and load time per test
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > cycle_limit) begin
         $display("Simulation timed out after %0d cycles", cycles);
         $display("Test FAILED");
         $fatal(1);
      end
   end

   initial begin
      nRst        <= 1'b0;
      load        <= '0;
      load_valid  <= 1'b0;
      start       <= 1'b0;
      out_ready   <= 1'b0;
      n_tests     = 0;
      err_cnt     = 0;
      cycles      <= 0;
      rng         = 32'h66ea;
      fill_tests();
      cycle_limit = 0;
      for (int t = 0; t < n_tests; t++) begin
         cycle_limit = cycle_limit + 200 * n_instr[t] + n_beats[t] + 40;
      end
      for (int t = 0; t < n_tests; t++) begin
         apply_reset();
         load_program(t);
         collect_output(t);
      end
      if (err_cnt == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
+incdir+bench
verilog/cpu_pkg.sv
verilog/cpu_control.sv
verilog/cpu_regfile.sv
verilog/cpu_alu.sv
verilog/cpu_fetch.sv
verilog/cpu_memory.sv
verilog/nibble_cpu.sv
bench/nibble_cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= files.f
TB_TOP    ?= nibble_cpu_tb
RTL_TOP   ?= nibble_cpu
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(BUILD_DIR)
